/* compile.f */
hw/fp_fmt_pkg.sv
hw/fp_op_pkg.sv
hw/fp_decomp.sv
hw/fp_cmp_in.sv
hw/fp_cmp_core.sv
hw/fp_cmp_out.sv
hw/fp_cmp_top.sv
testbench/tb_fp_cmp.sv

/* hw/fp_cmp_core.sv */
`timescale 1ns/1ps

// two-stage compare and classify pipeline
module fp_cmp_core
  import fp_op_pkg::*;
  import fp_fmt_pkg::*;
#(
  parameter int WID = 32
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           q_valid,
  input  fp_op_e         q_op,
  input  logic [WID-1:0] q_a,
  input  logic [WID-1:0] q_b,
  output logic           q_ready,
  output logic           c_valid,
  output logic [WID-1:0] c_result,
  output logic           c_invalid,
  input  logic           c_ready
);

  localparam int EW = (WID == 64) ? 11 : 8;  // exponent bits
  localparam int FW = WID - 1 - EW;          // stored fraction bits

  logic da_sgn, da_xz, da_mz, da_vz, da_inf, da_xinf, da_qnan, da_snan, da_nan;
  logic db_sgn, db_vz, db_snan, db_nan;  // b only feeds the compares
  logic [EW-1:0] da_exp, db_exp;
  logic [FW-1:0] da_man, db_man;

  fp_decomp #(.WID(WID)) u_dec_a (
    .i(q_a), .sgn(da_sgn), .exp(da_exp), .man(da_man), .fract(),
    .xz(da_xz), .mz(da_mz), .vz(da_vz), .inf(da_inf), .xinf(da_xinf),
    .qnan(da_qnan), .snan(da_snan), .nan(da_nan)
  );
  fp_decomp #(.WID(WID)) u_dec_b (
    .i(q_b), .sgn(db_sgn), .exp(db_exp), .man(db_man), .fract(),
    .xz(), .mz(), .vz(db_vz), .inf(), .xinf(),
    .qnan(), .snan(db_snan), .nan(db_nan)
  );

  // ==================================================
  // stage control, shared advance rule
  // ==================================================
  logic s1_valid, s2_valid, s1_adv, s2_adv;
  assign s2_adv  = ~s2_valid | c_ready;  // stage 2 empty or being taken
  assign s1_adv  = ~s1_valid | s2_adv;
  assign q_ready = s1_adv;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_adv) s1_valid <= q_valid;
      if (s2_adv) s2_valid <= s1_valid;
    end
  end

  // stage 1: fields {sgn,exp,man}, flags and opcode
  fp_op_e         s1_op;
  logic [WID-1:0] s1_a, s1_b;
  logic [7:0]     s1_fla;
  logic [2:0]     s1_flb;
  always_ff @(posedge clk) begin
    if (s1_adv && q_valid) begin
      s1_op  <= q_op;
      s1_a   <= {da_sgn, da_exp, da_man};
      s1_b   <= {db_sgn, db_exp, db_man};
      s1_fla <= {da_xz, da_mz, da_vz, da_inf, da_xinf, da_qnan, da_snan, da_nan};
      s1_flb <= {db_vz, db_snan, db_nan};
    end
  end

  logic a_xz, a_mz, a_vz, a_inf, a_xinf, a_qnan, a_snan, a_nan;
  logic b_vz, b_snan, b_nan;
  assign {a_xz, a_mz, a_vz, a_inf, a_xinf, a_qnan, a_snan, a_nan} = s1_fla;
  assign {b_vz, b_snan, b_nan} = s1_flb;

  // ==================================================
  // stage 2 datapath
  // ==================================================
  logic [CLASS_W-1:0] cls_a;
  always_comb begin
    cls_a = '0;
    cls_a[cls_neg_inf]  = s1_a[WID-1] & a_inf;
    cls_a[cls_neg_norm] = s1_a[WID-1] & ~a_xz & ~a_xinf;
    cls_a[cls_neg_sub]  = s1_a[WID-1] & a_xz & ~a_mz;
    cls_a[cls_neg_zero] = s1_a[WID-1] & a_vz;
    cls_a[cls_pos_zero] = ~s1_a[WID-1] & a_vz;
    cls_a[cls_pos_sub]  = ~s1_a[WID-1] & a_xz & ~a_mz;
    cls_a[cls_pos_norm] = ~s1_a[WID-1] & ~a_xz & ~a_xinf;
    cls_a[cls_pos_inf]  = ~s1_a[WID-1] & a_inf;
    cls_a[cls_snan]     = a_snan;   // nan classes ignore the sign
    cls_a[cls_qnan]     = a_qnan;
  end

  logic any_nan, any_snan, both_z, lt_z, eq_r, lt_r, le_r;
  logic [WID-1:0] min_v, max_v, qnan_c;
  assign any_nan  = a_nan | b_nan;
  assign any_snan = a_snan | b_snan;
  assign both_z   = a_vz & b_vz;
  // total order for non-nan values, -0 sorts below +0
  assign lt_z = (s1_a[WID-1] != s1_b[WID-1]) ? s1_a[WID-1] :
                s1_a[WID-1] ? (s1_b[WID-2:0] < s1_a[WID-2:0]) :
                              (s1_a[WID-2:0] < s1_b[WID-2:0]);
  assign eq_r = ~any_nan & ((s1_a == s1_b) | both_z);  // -0 == +0
  assign lt_r = ~any_nan & lt_z & ~both_z;
  assign le_r = lt_r | eq_r;

  assign qnan_c = {1'b0, {EW{1'b1}}, 1'b1, {(FW - 1){1'b0}}};  // canonical quiet nan
  assign min_v = (a_nan & b_nan) ? qnan_c : a_nan ? s1_b : b_nan ? s1_a :
                 lt_z ? s1_a : s1_b;
  assign max_v = (a_nan & b_nan) ? qnan_c : a_nan ? s1_b : b_nan ? s1_a :
                 lt_z ? s1_b : s1_a;

  logic [WID-1:0] res_d;
  logic           inv_d;
  always_comb begin
    res_d = '0;
    inv_d = 1'b0;
    case (s1_op)
      op_class: res_d = WID'(cls_a);
      op_eq: begin                     // quiet compare
        res_d[0] = eq_r;
        inv_d    = any_snan;
      end
      op_lt: begin
        res_d[0] = lt_r;
        inv_d    = any_nan;
      end
      op_le: begin
        res_d[0] = le_r;
        inv_d    = any_nan;
      end
      op_min: begin
        res_d = min_v;
        inv_d = any_snan;
      end
      op_max: begin
        res_d = max_v;
        inv_d = any_snan;
      end
      default:  ;                      // unused codes give zero
    endcase
  end

  always_ff @(posedge clk) begin
    if (s2_adv && s1_valid) begin
      c_result  <= res_d;
      c_invalid <= inv_d;
    end
  end
  assign c_valid = s2_valid;

  // a stalled result stays put until the buffer takes it
  a_hold: assert property (@(posedge clk) disable iff (rst)
    c_valid && !c_ready |=> c_valid && $stable(c_result) && $stable(c_invalid))
    else $error("fp_cmp_core: stage 2 changed while stalled");

endmodule : fp_cmp_core

/* hw/fp_cmp_in.sv */
`timescale 1ns/1ps

// request queue on the credit-controlled input side
module fp_cmp_in
  import fp_op_pkg::*;
#(
  parameter int WID      = 32,
  parameter int IN_DEPTH = 4
) (
  input  logic           clk,
  input  logic           rst,
  // upstream, credit based
  input  logic           in_valid,
  input  fp_op_e         in_op,
  input  logic [WID-1:0] in_a,
  input  logic [WID-1:0] in_b,
  output logic           in_credit,
  // toward the core, valid/ready
  output logic           q_valid,
  output fp_op_e         q_op,
  output logic [WID-1:0] q_a,
  output logic [WID-1:0] q_b,
  input  logic           q_ready
);

  localparam int PW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;

  fp_op_e         op_mem [IN_DEPTH];
  logic [WID-1:0] a_mem  [IN_DEPTH];
  logic [WID-1:0] b_mem  [IN_DEPTH];
  logic [PW-1:0]  wr_ptr;
  logic [PW-1:0]  rd_ptr;
  logic [PW-1:0]  wr_nxt;
  logic [PW-1:0]  rd_nxt;
  q_state_e       state;
  logic           wr;
  logic           pop;

  assign wr  = in_valid;              // sender only writes while holding a credit
  assign pop = q_valid & q_ready;

  // wrapping pointers, depth need not be a power of two
  assign wr_nxt = (wr_ptr == PW'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
  assign rd_nxt = (rd_ptr == PW'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

  // ==================================================
  // pointers, occupancy and credit return
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      state     <= q_empty;
      in_credit <= 1'b0;
    end else begin
      in_credit <= pop;               // one credit back per entry that leaves
      if (wr) wr_ptr <= wr_nxt;
      if (pop) rd_ptr <= rd_nxt;
      case ({wr, pop})
        2'b10:   state <= (wr_nxt == rd_ptr) ? q_full : q_partial;
        2'b01:   state <= (rd_nxt == wr_ptr) ? q_empty : q_partial;
        default: ;                    // idle, or one in and one out
      endcase
    end
  end

  // storage
  always_ff @(posedge clk) begin
    if (wr) begin
      op_mem[wr_ptr] <= in_op;
      a_mem[wr_ptr]  <= in_a;
      b_mem[wr_ptr]  <= in_b;
    end
  end

  assign q_valid = (state != q_empty);
  assign q_op    = op_mem[rd_ptr];    // head entry
  assign q_a     = a_mem[rd_ptr];
  assign q_b     = b_mem[rd_ptr];

  // a sender that honors its credits never finds the queue full
  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    in_valid |-> (state != q_full))
    else $error("fp_cmp_in: request written while the queue is full");

endmodule : fp_cmp_in

/* hw/fp_cmp_out.sv */
`timescale 1ns/1ps

// result buffer, spends consumer credits on the way out
module fp_cmp_out
  import fp_op_pkg::*;
#(
  parameter int WID         = 32,
  parameter int OUT_DEPTH   = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           c_valid,
  input  logic [WID-1:0] c_result,
  input  logic           c_invalid,
  output logic           c_ready,
  output logic           out_valid,
  output logic [WID-1:0] out_result,
  output logic           out_invalid,
  input  logic           out_credit
);

  localparam int PW = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
  localparam int CW = $clog2(OUT_CREDITS + 1);

  logic [WID-1:0] res_mem [OUT_DEPTH];
  logic           inv_mem [OUT_DEPTH];
  logic [PW-1:0]  wr_ptr, rd_ptr;
  logic [PW-1:0]  wr_nxt, rd_nxt;
  logic [CW-1:0]  credits;            // sends still allowed downstream
  q_state_e       state;
  logic           wr;

  assign c_ready = (state != q_full);
  assign wr      = c_valid & c_ready;
  assign wr_nxt  = (wr_ptr == PW'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
  assign rd_nxt  = (rd_ptr == PW'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

  // head leaves whenever a credit is held, consumer has no stall
  assign out_valid   = (state != q_empty) && (credits != '0);
  assign out_result  = res_mem[rd_ptr];
  assign out_invalid = inv_mem[rd_ptr];

  // ==================================================
  // buffer state and credit counter
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      state   <= q_empty;
      credits <= CW'(OUT_CREDITS);
    end else begin
      if (wr) wr_ptr <= wr_nxt;
      if (out_valid) rd_ptr <= rd_nxt;
      case ({wr, out_valid})
        2'b10:   state <= (wr_nxt == rd_ptr) ? q_full : q_partial;
        2'b01:   state <= (rd_nxt == wr_ptr) ? q_empty : q_partial;
        default: ;
      endcase
      case ({out_valid, out_credit})
        2'b10:   credits <= credits - 1'b1;  // spent on a send
        2'b01:   credits <= credits + 1'b1;  // returned by the consumer
        default: ;                           // both or neither, no change
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      res_mem[wr_ptr] <= c_result;
      inv_mem[wr_ptr] <= c_invalid;
    end
  end

  // consumer never returns more than it was granted
  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    credits <= CW'(OUT_CREDITS))
    else $error("fp_cmp_out: credit count above the grant");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    out_valid |-> (credits != '0))
    else $error("fp_cmp_out: result sent without a credit");

endmodule : fp_cmp_out

/* hw/fp_cmp_top.sv */
`timescale 1ns/1ps

// compare and classify unit, credit interfaces on both ends
module fp_cmp_top
  import fp_op_pkg::*;
#(
  parameter int WID         = 32,
  parameter int IN_DEPTH    = 4,
  parameter int OUT_DEPTH   = 4,
  parameter int OUT_CREDITS = 4
) (
  input  logic           clk,
  input  logic           rst,
  input  logic           in_valid,
  input  fp_op_e         in_op,
  input  logic [WID-1:0] in_a,
  input  logic [WID-1:0] in_b,
  output logic           in_credit,
  output logic           out_valid,
  output logic [WID-1:0] out_result,
  output logic           out_invalid,
  input  logic           out_credit
);

  // queue to core
  logic           q_valid, q_ready;
  fp_op_e         q_op;
  logic [WID-1:0] q_a, q_b;
  // core to buffer
  logic           c_valid, c_ready, c_invalid;
  logic [WID-1:0] c_result;

  fp_cmp_in #(.WID(WID), .IN_DEPTH(IN_DEPTH)) u_in (
    .clk(clk), .rst(rst),
    .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b),
    .in_credit(in_credit),
    .q_valid(q_valid), .q_op(q_op), .q_a(q_a), .q_b(q_b), .q_ready(q_ready)
  );

  fp_cmp_core #(.WID(WID)) u_core (
    .clk(clk), .rst(rst),
    .q_valid(q_valid), .q_op(q_op), .q_a(q_a), .q_b(q_b), .q_ready(q_ready),
    .c_valid(c_valid), .c_result(c_result), .c_invalid(c_invalid), .c_ready(c_ready)
  );

  fp_cmp_out #(.WID(WID), .OUT_DEPTH(OUT_DEPTH), .OUT_CREDITS(OUT_CREDITS)) u_out (
    .clk(clk), .rst(rst),
    .c_valid(c_valid), .c_result(c_result), .c_invalid(c_invalid), .c_ready(c_ready),
    .out_valid(out_valid), .out_result(out_result), .out_invalid(out_invalid),
    .out_credit(out_credit)
  );

endmodule : fp_cmp_top

/* hw/fp_decomp.sv */
`timescale 1ns/1ps

// splits one ieee operand into fields and special-value flags
module fp_decomp #(
  parameter  int WID  = 32,
  // exponent msb from the width table; the fraction takes what is left
  localparam int EMSB = (WID == 128 || WID == 96 || WID == 80) ? 14 :
                        (WID == 64 || WID == 52 || WID == 44 || WID == 42) ? 10 :
                        (WID == 48) ? 11 :
                        (WID == 40) ? 9 :
                        (WID == 32) ? 7 :
                        (WID == 24) ? 6 : 4,
  localparam int FMSB = WID - EMSB - 3  // sign and exponent take the rest
) (
  input  logic [WID-1:0]  i,
  output logic            sgn,
  output logic [EMSB:0]   exp,
  output logic [FMSB:0]   man,
  output logic [FMSB+1:0] fract,  // mantissa with hidden bit in front
  output logic            xz,     // exponent all zeros
  output logic            mz,     // mantissa all zeros
  output logic            vz,     // zero value, either sign
  output logic            inf,    // infinity, either sign
  output logic            xinf,   // exponent all ones
  output logic            qnan,   // quiet nan
  output logic            snan,   // signaling nan
  output logic            nan     // any nan
);

  // raw fields
  assign sgn = i[WID-1];
  assign exp = i[WID-2:FMSB+1];
  assign man = i[FMSB:0];

  // ==================================================
  // field tests
  // ==================================================
  assign xz   = ~|exp;
  assign mz   = ~|man;
  assign xinf = &exp;
  assign vz   = xz & mz;

  // all-ones exponent splits into infinity and the nan family
  assign inf  = xinf & mz;
  assign nan  = xinf & ~mz;
  assign qnan = xinf & man[FMSB];                 // quiet bit set
  assign snan = xinf & ~man[FMSB] & ~mz;          // quiet bit clear, payload nonzero

  // hidden bit is one unless the exponent is zero
  assign fract = {~xz, man};

endmodule : fp_decomp

/* hw/fp_fmt_pkg.sv */
package fp_fmt_pkg;

  // ==================================================
  // class mask layout
  // ==================================================
  // one-hot bit positions inside the class result, lowest bit first
  // order follows the usual fclass convention: negative side, zeros,
  // positive side, then the two nan kinds
  typedef enum logic [3:0] {
    cls_neg_inf  = 4'd0,  // -infinity
    cls_neg_norm = 4'd1,  // negative normal
    cls_neg_sub  = 4'd2,  // negative subnormal
    cls_neg_zero = 4'd3,  // -0
    cls_pos_zero = 4'd4,  // +0
    cls_pos_sub  = 4'd5,  // positive subnormal
    cls_pos_norm = 4'd6,  // positive normal
    cls_pos_inf  = 4'd7,  // +infinity
    cls_snan     = 4'd8,  // signaling nan, sign ignored
    cls_qnan     = 4'd9   // quiet nan, sign ignored
  } fp_class_e;

  // width of the class mask, one bit per fp_class_e value
  parameter int CLASS_W = 10;

  // exactly one bit of the mask is set for any operand;
  // the core zero-extends the mask to the operand width before it
  // leaves as a result, so the upper bits of a class result are zero

endpackage : fp_fmt_pkg

/* hw/fp_op_pkg.sv */
package fp_op_pkg;

  // ==================================================
  // operation codes
  // ==================================================
  // carried with every request from the input queue to the core
  typedef enum logic [2:0] {
    op_class = 3'd0,  // class mask of operand a
    op_eq    = 3'd1,  // a == b, quiet
    op_lt    = 3'd2,  // a <  b, signaling
    op_le    = 3'd3,  // a <= b, signaling
    op_min   = 3'd4,  // smaller of a and b
    op_max   = 3'd5   // larger of a and b
  } fp_op_e;
  // codes 6 and 7 are unused, the core returns zero for them

  // ==================================================
  // queue occupancy
  // ==================================================
  // shared by the input queue and the output buffer
  typedef enum logic [1:0] {
    q_empty   = 2'd0,  // nothing stored
    q_partial = 2'd1,  // at least one entry, at least one free slot
    q_full    = 2'd2   // every slot taken
  } q_state_e;

  // partial covers every fill level between the two ends, so a queue
  // only has to look at its pointers when it moves toward an end

endpackage : fp_op_pkg

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and inspects the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module tb_fp_cmp --Mdir obj_dir -o tb_fp_cmp > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_fp_cmp > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Test failures found" sim.log; then
  exit 1
fi
exit 0

/* testbench/tb_fp_cmp.sv */
`timescale 1ns/1ps

module tb_fp_cmp
  import fp_op_pkg::*;
  import fp_fmt_pkg::*;
;

  localparam int IN_DEPTH    = 4;
  localparam int OUT_DEPTH   = 4;
  localparam int OUT_CREDITS = 4;
  localparam int LIMIT       = 2000;  // cycles any single wait may take

  logic clk, rst, in_valid, in_credit, out_valid, out_invalid, out_credit;
  fp_op_e in_op;
  logic [31:0] in_a, in_b, out_result;

  logic [32:0] exp_q [$];   // {invalid, result} in request order
  string       name_q [$];
  int  checks, errors, chk0, err0, req_cnt, in_credit_cnt, out_cnt, ret_cnt;
  bit  hold, timed_out;
  // one of each class, reused for pairs and random specials
  logic [31:0] spec_v [10] = '{32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 32'h8000_0001,
                              32'h3f80_0000, 32'hbf80_0000, 32'h7f80_0000, 32'hff80_0000,
                              32'h7f80_0001, 32'h7fc0_0000};

  fp_cmp_top #(.WID(32), .IN_DEPTH(IN_DEPTH), .OUT_DEPTH(OUT_DEPTH),
               .OUT_CREDITS(OUT_CREDITS)) dut (
    .clk(clk), .rst(rst), .in_valid(in_valid), .in_op(in_op), .in_a(in_a), .in_b(in_b),
    .in_credit(in_credit), .out_valid(out_valid), .out_result(out_result),
    .out_invalid(out_invalid), .out_credit(out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // ==================================================
  // reference model
  // ==================================================
  function automatic logic is_nan(logic [31:0] x);
    return (&x[30:23]) && (|x[22:0]);
  endfunction

  function automatic logic [31:0] order_key(logic [31:0] x);
    return x[31] ? {1'b0, ~x[30:0]} : {1'b1, x[30:0]};  // -0 lands just below +0
  endfunction

  function automatic logic [CLASS_W-1:0] class_mask(logic [31:0] x);
    logic [CLASS_W-1:0] m;
    m = '0;
    if (is_nan(x)) m[x[22] ? cls_qnan : cls_snan] = 1'b1;   // sign ignored
    else if (&x[30:23]) m[x[31] ? cls_neg_inf : cls_pos_inf] = 1'b1;
    else if (x[30:0] == 0) m[x[31] ? cls_neg_zero : cls_pos_zero] = 1'b1;
    else if (x[30:23] == 0) m[x[31] ? cls_neg_sub : cls_pos_sub] = 1'b1;
    else m[x[31] ? cls_neg_norm : cls_pos_norm] = 1'b1;
    return m;
  endfunction

  function automatic logic [32:0] fp_ref(fp_op_e op, logic [31:0] a, logic [31:0] b);
    logic        a_nan, b_nan, any_snan, both_zero, less, equal, inv;
    logic [31:0] res;
    a_nan     = is_nan(a);
    b_nan     = is_nan(b);
    any_snan  = (a_nan && !a[22]) || (b_nan && !b[22]);
    both_zero = (a[30:0] == 0) && (b[30:0] == 0);
    less      = order_key(a) < order_key(b);
    equal     = !a_nan && !b_nan && ((a == b) || both_zero);
    res = '0;
    inv = 1'b0;
    case (op)
      op_class: res = 32'(class_mask(a));
      op_eq: begin  // quiet
        res[0] = equal;
        inv    = any_snan;
      end
      op_lt: begin
        res[0] = !a_nan && !b_nan && less && !both_zero;
        inv    = a_nan | b_nan;
      end
      op_le: begin
        res[0] = equal || (!a_nan && !b_nan && less);
        inv    = a_nan | b_nan;
      end
      op_min, op_max: begin
        if (a_nan && b_nan) res = 32'h7fc0_0000;  // canonical quiet nan
        else if (a_nan) res = b;
        else if (b_nan) res = a;
        else res = ((op == op_min) == less) ? a : b;
        inv = any_snan;
      end
      default: ;
    endcase
    return {inv, res};
  endfunction

  // ==================================================
  // checking and reporting
  // ==================================================
  task automatic check_value(string name, logic [63:0] expected, logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) $display("All tests passed!");
    else $display("Test failures found");
    $finish;
  endtask

  task automatic abort_run(string why);
    $display("timeout: %s", why);
    timed_out = 1'b1;
    finish_run();
  endtask

  function automatic int credits_held();
    return IN_DEPTH - req_cnt + in_credit_cnt;
  endfunction

  // outputs sampled mid-cycle, well away from the edges
  always @(negedge clk) begin
    if (!rst) begin
      if (in_credit) in_credit_cnt++;
      if (out_valid) begin
        out_cnt++;
        if (out_cnt > OUT_CREDITS + ret_cnt) begin
          errors++;
          $display("a result was sent without a credit from the consumer");
        end
        if (exp_q.size() == 0) begin
          errors++;
          $display("a result arrived with no request outstanding");
        end else check_value(name_q.pop_front(), exp_q.pop_front(), {out_invalid, out_result});
      end
    end
  end

  // consumer, returns each credit after a random delay unless held back
  initial begin
    out_credit = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      out_credit = 1'b0;
      if (!rst && !hold && (out_cnt > ret_cnt) && ($urandom % 3 == 0)) begin
        out_credit = 1'b1;
        ret_cnt++;
      end
    end
  end

  // ==================================================
  // driver
  // ==================================================
  task automatic send_req(fp_op_e op, logic [31:0] a, logic [31:0] b, string name);
    int waited;
    waited = 0;
    while (credits_held() == 0 && waited < LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (credits_held() == 0) abort_run("no input credit came back from the DUT");
    in_valid = 1'b1;
    in_op    = op;
    in_a     = a;
    in_b     = b;
    req_cnt++;
    exp_q.push_back(fp_ref(op, a, b));
    name_q.push_back(name);
    @(posedge clk);
    #1;
    in_valid = 1'b0;
  endtask

  task automatic end_test(string name);
    int waited;
    waited = 0;
    while ((exp_q.size() != 0 || out_cnt != ret_cnt) && waited < LIMIT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (exp_q.size() != 0) abort_run($sformatf("results of test %s never arrived", name));
    repeat (2) @(posedge clk);  // last returned credit reaches the DUT
    #1;
    $display("test %-14s %0d checks, %0d errors", name, checks - chk0, errors - err0);
    chk0 = checks;
    err0 = errors;
  endtask

  function automatic logic [31:0] pick_operand();
    if ($urandom % 4 == 0) return spec_v[$urandom % 10];
    return $urandom;
  endfunction

  initial begin
    int waited, bp_sent, c0;
    logic [31:0] a;
    void'($urandom(32'h9b53));
    rst = 1'b1;
    in_valid = 1'b0;
    in_op = op_class;
    in_a = '0;
    in_b = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    for (int i = 0; i < 10; i++)
      send_req(op_class, spec_v[i], '0, $sformatf("class %h", spec_v[i]));
    end_test("class");
    for (int k = 1; k <= 3; k++)   // eq, lt, le over every class pair
      for (int i = 0; i < 10; i++)
        for (int j = 0; j < 10; j++)
          send_req(fp_op_e'(k), spec_v[i], spec_v[j],
                   $sformatf("op%0d %h %h", k, spec_v[i], spec_v[j]));
    end_test("compare");
    for (int k = 4; k <= 5; k++)   // min, max
      for (int i = 0; i < 10; i++)
        for (int j = 0; j < 10; j++)
          send_req(fp_op_e'(k), spec_v[i], spec_v[j],
                   $sformatf("op%0d %h %h", k, spec_v[i], spec_v[j]));
    end_test("min_max");
    for (int i = 0; i < 300; i++) begin
      a = pick_operand();
      send_req(fp_op_e'($urandom % 6), a, ($urandom % 8 == 0) ? a : pick_operand(),
               $sformatf("random %0d", i));
    end
    end_test("random");

    // consumer holds every credit, the whole path fills up
    hold = 1'b1;
    bp_sent = 0;
    for (int i = 0; i < 20; i++) begin
      waited = 0;
      while (credits_held() == 0 && waited < 30) begin  // a stall is expected here
        @(posedge clk);
        #1;
        waited++;
      end
      if (credits_held() == 0) break;
      send_req(fp_op_e'($urandom % 6), pick_operand(), pick_operand(), $sformatf("bp %0d", i));
      bp_sent++;
    end
    check_value("bp accepted", OUT_CREDITS + OUT_DEPTH + 2 + IN_DEPTH, bp_sent);
    c0 = in_credit_cnt;
    repeat (20) @(posedge clk);
    #1;
    check_value("bp in_credit quiet", c0, in_credit_cnt);
    hold = 1'b0;
    end_test("backpressure");

    check_value("credit returns", req_cnt, in_credit_cnt);
    check_value("driver credits", IN_DEPTH, credits_held());
    end_test("accounting");
    finish_run();
  end

endmodule : tb_fp_cmp
